// ==== list.f ====
tanimoto_pkg.sv
threshold_table.sv
ref_stage.sv
id_fifo.sv
merge_node.sv
tanimoto_top.sv
tb_clk_gen.sv
tanimoto_sva.sv
tanimoto_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tanimoto_tb -f list.f -o sim_tanimoto

out=$(./obj_dir/sim_tanimoto 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
else
    exit 1
fi

// ==== tanimoto_tb.sv ====
`default_nettype none

module tanimoto_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_CMP    = 40;
    localparam int N_RUNS   = 2;
    localparam int N_BEATS  = N_RUNS * (tanimoto_pkg::N_REF + N_CMP);
    localparam int WD_LIMIT = 200 * N_BEATS + 2000;

    logic                   clk;
    logic                   rstn;
    logic [31:0]            i_in_vec;
    logic                   i_in_valid;
    logic                   i_in_last;
    logic                   o_in_ready;
    tanimoto_pkg::wb_req_t  i_wb;
    logic [6:0]             o_wb_dat;
    logic                   o_wb_ack;
    tanimoto_pkg::id_pair_t o_res;
    logic                   o_res_last;
    logic                   o_res_valid;
    logic                   i_res_ready;

    // Model state
    logic [6:0]  tbl [33];
    logic [31:0] refs [4];
    int          exp_hits [int];
    int          pending;
    bit          saw_stall;

    tb_clk_gen u_tb_clk_gen (.o_clk(clk));

    tanimoto_top u_tanimoto_top (
        .clk         (clk),
        .rstn        (rstn),
        .i_in_vec    (i_in_vec),
        .i_in_valid  (i_in_valid),
        .i_in_last   (i_in_last),
        .o_in_ready  (o_in_ready),
        .i_wb        (i_wb),
        .o_wb_dat    (o_wb_dat),
        .o_wb_ack    (o_wb_ack),
        .o_res       (o_res),
        .o_res_last  (o_res_last),
        .o_res_valid (o_res_valid),
        .i_res_ready (i_res_ready)
    );

    bind tanimoto_top tanimoto_sva u_tanimoto_sva (
        .clk         (clk),
        .rstn        (rstn),
        .i_in_ready  (o_in_ready),
        .i_wb_ack    (o_wb_ack),
        .i_res       (o_res),
        .i_res_last  (o_res_last),
        .i_res_valid (o_res_valid),
        .i_res_ready (i_res_ready)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED time=%0t %s got 0x%0h expected 0x%0h",
                                        $time, name, got, exp));
        end
    endtask

    function automatic int count_bits(input logic [31:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            n += int'(v[i]);
        end
        return n;
    endfunction

    // One Wishbone classic cycle with the strobe held through the cycle after ack
    task automatic wb_access(input bit we, input int adr, input int dat,
                             output logic [6:0] rdat);
        i_wb.cyc = 1'b1;
        i_wb.stb = 1'b1;
        i_wb.we  = we;
        i_wb.adr = 6'(adr);
        i_wb.dat = 7'(dat);
        @(posedge clk);
        #1;
        check_value("o_wb_ack", 32'(o_wb_ack), 32'd1);
        rdat = o_wb_dat;
        @(posedge clk);
        #1;
        check_value("o_wb_ack", 32'(o_wb_ack), 32'd0);
        i_wb = '0;
    endtask

    task automatic load_table(input int min_val);
        logic [6:0] rd;
        for (int i = 0; i < 33; i++) begin
            tbl[i] = 7'($urandom_range(64, min_val));
            wb_access(1'b1, i, int'(tbl[i]), rd);
        end
        for (int i = 0; i < 33; i++) begin
            wb_access(1'b0, i, 0, rd);
            check_value($sformatf("o_wb_dat[%0d]", i), 32'(rd), 32'(tbl[i]));
        end
        wb_access(1'b0, 40, 0, rd);
        check_value("o_wb_dat[40]", 32'(rd), 32'd0);
    endtask

    // Expected hits of one compared vector against all four references
    task automatic add_expected(input logic [31:0] vec, input int cid);
        int a;
        int b;
        int c;
        int key;
        b = count_bits(vec);
        for (int r = 0; r < 4; r++) begin
            a = count_bits(refs[r]);
            c = count_bits(refs[r] & vec);
            if (a + b <= int'(tbl[c])) begin
                key = r * 256 + cid;
                if (exp_hits.exists(key)) begin
                    exp_hits[key]++;
                end else begin
                    exp_hits[key] = 1;
                end
                pending++;
            end
        end
    endtask

    task automatic send_beat(input logic [31:0] vec, input logic last);
        i_in_vec   = vec;
        i_in_last  = last;
        i_in_valid = 1'b1;
        do begin
            @(negedge clk);
            if (!o_in_ready) begin
                saw_stall = 1'b1;
            end
        end while (!o_in_ready);
        @(posedge clk);
        #1;
        i_in_valid = 1'b0;
        i_in_last  = 1'b0;
    endtask

    task automatic feed_run();
        logic [31:0] vec;
        for (int i = 0; i < tanimoto_pkg::N_REF + N_CMP; i++) begin
            vec = $urandom();
            repeat ($urandom_range(2, 0)) begin
                @(posedge clk);
                #1;
            end
            send_beat(vec, i == tanimoto_pkg::N_REF + N_CMP - 1);
            if (i < tanimoto_pkg::N_REF) begin
                refs[i] = vec;
            end else begin
                add_expected(vec, i);
            end
        end
    endtask

    task automatic collect_run(input bit slow);
        bit done;
        int key;
        int stall_left;
        done       = 1'b0;
        stall_left = 0;
        while (!done) begin
            @(posedge clk);
            #1;
            if (stall_left > 0) begin
                i_res_ready = 1'b0;
                stall_left--;
            end else if (slow && $urandom_range(9, 0) == 0) begin
                i_res_ready = 1'b0;
                stall_left  = $urandom_range(60, 20);
            end else begin
                i_res_ready = ($urandom_range(3, 0) != 0);
            end
            @(negedge clk);
            if (o_res_valid && i_res_ready) begin
                if (o_res_last) begin
                    check_value("o_res", 32'(o_res), 32'd0);
                    if (pending != 0) begin
                        stop_with_failure($sformatf(
                            "%0d expected pairs had not arrived before the last beat", pending));
                    end
                    done = 1'b1;
                end else begin
                    key = int'(o_res.id_a) * 256 + int'(o_res.id_b);
                    if (!exp_hits.exists(key) || exp_hits[key] == 0) begin
                        stop_with_failure($sformatf("Unexpected pair (%0d, %0d) at %0t",
                                                    o_res.id_a, o_res.id_b, $time));
                    end
                    exp_hits[key]--;
                    pending--;
                end
            end
        end
    endtask

    task automatic run_once(input bit slow);
        exp_hits.delete();
        pending   = 0;
        saw_stall = 1'b0;
        fork
            feed_run();
            collect_run(slow);
        join
        // The closing beat transfers at this edge and nothing may follow it
        @(posedge clk);
        #1;
        i_res_ready = 1'b1;
        @(negedge clk);
        check_value("o_res_valid", 32'(o_res_valid), 32'd0);
        check_value("o_in_ready", 32'(o_in_ready), 32'd1);
        @(posedge clk);
        #1;
        i_res_ready = 1'b0;
    endtask

    initial begin
        repeat (WD_LIMIT) @(posedge clk);
        stop_with_failure($sformatf("Watchdog expired after %0d cycles", WD_LIMIT));
    end

    initial begin
        void'($urandom(26732));
        rstn        = 1'b0;
        i_in_vec    = '0;
        i_in_valid  = 1'b0;
        i_in_last   = 1'b0;
        i_wb        = '0;
        i_res_ready = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        check_value("o_res_valid", 32'(o_res_valid), 32'd0);
        check_value("o_wb_ack", 32'(o_wb_ack), 32'd0);
        check_value("o_in_ready", 32'(o_in_ready), 32'd1);

        // Run 1 with a fully random table
        load_table(0);
        run_once(1'b0);

        // Run 2 with a permissive table and long output stalls
        load_table(40);
        run_once(1'b1);
        if (!saw_stall) begin
            stop_with_failure("o_in_ready never dropped under output back-pressure");
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tanimoto_sva.sv ====
`default_nettype none

module tanimoto_sva (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_in_ready,
    input  logic                   i_wb_ack,
    input  tanimoto_pkg::id_pair_t i_res,
    input  logic                   i_res_last,
    input  logic                   i_res_valid,
    input  logic                   i_res_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    // Single cycle ack, even with the strobe held
    a_ack_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        i_wb_ack |=> !i_wb_ack)
        else $error("o_wb_ack stayed high for more than one cycle");

    // Output beat holds while stalled
    a_res_stable: assert property (@(posedge clk) disable iff (!rstn)
        (i_res_valid && !i_res_ready) |=>
        (i_res_valid && $stable(i_res) && $stable(i_res_last)))
        else $error("output beat changed while stalled");

    a_ready_after_reset: assert property (@(posedge clk)
        $rose(rstn) |-> i_in_ready)
        else $error("o_in_ready low after reset");

    a_last_is_zero: assert property (@(posedge clk) disable iff (!rstn)
        i_res_last |-> (i_res == '0))
        else $error("closing beat carries a nonzero pair");

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen (
    output logic o_clk
);

    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

// ==== tanimoto_top.sv ====
`default_nettype none

module tanimoto_top (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic [tanimoto_pkg::VEC_W-1:0]      i_in_vec,
    input  logic                                i_in_valid,
    input  logic                                i_in_last,
    output logic                                o_in_ready,
    input  tanimoto_pkg::wb_req_t               i_wb,
    output logic [tanimoto_pkg::SUM_W-1:0]      o_wb_dat,
    output logic                                o_wb_ack,
    output tanimoto_pkg::id_pair_t              o_res,
    output logic                                o_res_last,
    output logic                                o_res_valid,
    input  logic                                i_res_ready
);

    tanimoto_pkg::run_state_t               r_state;
    logic [tanimoto_pkg::ID_W-1:0]          r_id;
    logic                                   r_last_seen;
    logic                                   r_last_left;
    tanimoto_pkg::vec_beat_t                r_in_beat;
    logic                                   r_in_is_ref;
    logic                                   w_in_fire;
    logic                                   w_room;
    logic                                   w_ref_shift;
    logic                                   w_all_empty;
    logic                                   w_run_done;
    logic                                   w_res_rd;
    tanimoto_pkg::vec_beat_t                w_ref_chain [tanimoto_pkg::N_REF+1];
    tanimoto_pkg::vec_beat_t                w_cmp_chain [tanimoto_pkg::N_REF+1];
    logic [tanimoto_pkg::CNT_W-1:0]         w_and_cnt [tanimoto_pkg::N_REF];
    logic [tanimoto_pkg::SUM_W-1:0]         w_max_sum [tanimoto_pkg::N_REF];
    logic [tanimoto_pkg::N_REF-1:0]         w_hit_wr;
    tanimoto_pkg::id_pair_t                 w_hit_pair [tanimoto_pkg::N_REF];
    logic [tanimoto_pkg::N_REF-1:0]         w_leaf_rd;
    logic [tanimoto_pkg::N_REF-1:0]         w_leaf_empty;
    tanimoto_pkg::id_pair_t                 w_leaf_dout [tanimoto_pkg::N_REF];
    logic [tanimoto_pkg::FIFO_CNT_W-1:0]    w_leaf_cnt [tanimoto_pkg::N_REF];
    logic [2:0]                             w_node_empty;
    tanimoto_pkg::id_pair_t                 w_node_dout [3];
    logic [1:0]                             w_node_rd;

    // Leaves keep room for every beat still in the pipeline
    always_comb begin
        w_room = 1'b1;
        for (int k = 0; k < tanimoto_pkg::N_REF; k++) begin
            if (w_leaf_cnt[k] > tanimoto_pkg::FIFO_CNT_W'(tanimoto_pkg::FIFO_DEPTH
                                                          - tanimoto_pkg::IN_FLIGHT_SLACK)) begin
                w_room = 1'b0;
            end
        end
    end

    assign o_in_ready = w_room & ((r_state == tanimoto_pkg::LOAD_REF) ||
                                  (r_state == tanimoto_pkg::COMPARE && !r_last_seen));
    assign w_in_fire  = i_in_valid & o_in_ready;

    assign w_all_empty = (&w_leaf_empty) & (&w_node_empty);
    assign w_run_done  = r_last_left & ~(|w_hit_wr) & w_all_empty;

    // Run sequencing
    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_state     <= tanimoto_pkg::LOAD_REF;
            r_id        <= '0;
            r_last_seen <= 1'b0;
            r_last_left <= 1'b0;
        end else begin
            if (w_in_fire) begin
                r_id <= r_id + 1'b1;
            end
            case (r_state)
                tanimoto_pkg::LOAD_REF: begin
                    if (w_in_fire && r_id == tanimoto_pkg::ID_W'(tanimoto_pkg::N_REF - 1)) begin
                        r_state <= tanimoto_pkg::COMPARE;
                    end
                end
                tanimoto_pkg::COMPARE: begin
                    if (w_in_fire && i_in_last) begin
                        r_last_seen <= 1'b1;
                    end
                    // Final beat seen leaving the last stage
                    if (w_cmp_chain[tanimoto_pkg::N_REF].valid &&
                        w_cmp_chain[tanimoto_pkg::N_REF].last) begin
                        r_last_left <= 1'b1;
                    end
                    if (w_run_done) begin
                        r_state <= tanimoto_pkg::OVER;
                    end
                end
                default: begin
                    if (i_res_ready) begin
                        r_state     <= tanimoto_pkg::LOAD_REF;
                        r_id        <= '0;
                        r_last_seen <= 1'b0;
                        r_last_left <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Count stage, the beat with its ones count
    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_in_beat.valid <= 1'b0;
            r_in_is_ref     <= 1'b0;
        end else begin
            r_in_beat.vector <= i_in_vec;
            r_in_beat.count  <= tanimoto_pkg::ones_count(i_in_vec);
            r_in_beat.id     <= r_id;
            r_in_beat.valid  <= w_in_fire;
            r_in_beat.last   <= i_in_last;
            r_in_is_ref      <= (r_state == tanimoto_pkg::LOAD_REF);
        end
    end

    // Route to the reference chain or the compare chain
    assign w_ref_shift = r_in_beat.valid & r_in_is_ref;

    always_comb begin
        w_ref_chain[0]       = r_in_beat;
        w_cmp_chain[0]       = r_in_beat;
        w_cmp_chain[0].valid = r_in_beat.valid & ~r_in_is_ref;
    end

    threshold_table u_threshold_table (
        .clk          (clk),
        .rstn         (rstn),
        .i_wb         (i_wb),
        .o_wb_dat     (o_wb_dat),
        .o_wb_ack     (o_wb_ack),
        .i_lookup_cnt (w_and_cnt),
        .o_lookup_max (w_max_sum)
    );

    for (genvar k = 0; k < tanimoto_pkg::N_REF; k++) begin : g_stage
        ref_stage u_ref_stage (
            .clk         (clk),
            .rstn        (rstn),
            .i_ref_shift (w_ref_shift),
            .i_ref       (w_ref_chain[k]),
            .o_ref       (w_ref_chain[k+1]),
            .i_cmp       (w_cmp_chain[k]),
            .o_cmp       (w_cmp_chain[k+1]),
            .o_and_cnt   (w_and_cnt[k]),
            .i_max_sum   (w_max_sum[k]),
            .o_hit_wr    (w_hit_wr[k]),
            .o_hit_pair  (w_hit_pair[k])
        );

        id_fifo u_leaf_fifo (
            .clk     (clk),
            .rstn    (rstn),
            .i_wr    (w_hit_wr[k]),
            .i_din   (w_hit_pair[k]),
            .i_rd    (w_leaf_rd[k]),
            .o_dout  (w_leaf_dout[k]),
            .o_empty (w_leaf_empty[k]),
            .o_full  (),
            .o_count (w_leaf_cnt[k])
        );
    end

    // First merge level, two leaves per node
    for (genvar n = 0; n < 2; n++) begin : g_merge
        merge_node u_merge_node (
            .clk       (clk),
            .rstn      (rstn),
            .i_a_empty (w_leaf_empty[2*n]),
            .i_a_dout  (w_leaf_dout[2*n]),
            .o_a_rd    (w_leaf_rd[2*n]),
            .i_b_empty (w_leaf_empty[2*n+1]),
            .i_b_dout  (w_leaf_dout[2*n+1]),
            .o_b_rd    (w_leaf_rd[2*n+1]),
            .i_rd      (w_node_rd[n]),
            .o_dout    (w_node_dout[n]),
            .o_empty   (w_node_empty[n])
        );
    end

    merge_node u_merge_root (
        .clk       (clk),
        .rstn      (rstn),
        .i_a_empty (w_node_empty[0]),
        .i_a_dout  (w_node_dout[0]),
        .o_a_rd    (w_node_rd[0]),
        .i_b_empty (w_node_empty[1]),
        .i_b_dout  (w_node_dout[1]),
        .o_b_rd    (w_node_rd[1]),
        .i_rd      (w_res_rd),
        .o_dout    (w_node_dout[2]),
        .o_empty   (w_node_empty[2])
    );

    // Closing beat replaces the root FIFO once the run is over
    assign w_res_rd    = i_res_ready & (r_state != tanimoto_pkg::OVER);
    assign o_res_last  = (r_state == tanimoto_pkg::OVER);
    assign o_res_valid = o_res_last | ~w_node_empty[2];
    assign o_res       = o_res_last ? '0 : w_node_dout[2];

endmodule

`default_nettype wire

// ==== merge_node.sv ====
`default_nettype none

module merge_node (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    i_a_empty,
    input  tanimoto_pkg::id_pair_t  i_a_dout,
    output logic                    o_a_rd,
    input  logic                    i_b_empty,
    input  tanimoto_pkg::id_pair_t  i_b_dout,
    output logic                    o_b_rd,
    input  logic                    i_rd,
    output tanimoto_pkg::id_pair_t  o_dout,
    output logic                    o_empty
);

    logic                   r_last_b;
    logic                   w_sel_b;
    logic                   w_take;
    logic                   w_full;
    tanimoto_pkg::id_pair_t w_din;

    // Alternate when both children hold data, else take whichever has some
    always_comb begin
        if (!i_a_empty && !i_b_empty) begin
            w_sel_b = ~r_last_b;
        end else begin
            w_sel_b = i_a_empty;
        end
    end

    assign w_take = (~i_a_empty | ~i_b_empty) & ~w_full;
    assign o_a_rd = w_take & ~w_sel_b;
    assign o_b_rd = w_take & w_sel_b;
    assign w_din  = w_sel_b ? i_b_dout : i_a_dout;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_last_b <= 1'b0;
        end else if (w_take) begin
            r_last_b <= w_sel_b;
        end
    end

    id_fifo u_id_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .i_wr    (w_take),
        .i_din   (w_din),
        .i_rd    (i_rd),
        .o_dout  (o_dout),
        .o_empty (o_empty),
        .o_full  (w_full),
        .o_count ()
    );

endmodule

`default_nettype wire

// ==== id_fifo.sv ====
`default_nettype none

module id_fifo (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                i_wr,
    input  tanimoto_pkg::id_pair_t              i_din,
    input  logic                                i_rd,
    output tanimoto_pkg::id_pair_t              o_dout,
    output logic                                o_empty,
    output logic                                o_full,
    output logic [tanimoto_pkg::FIFO_CNT_W-1:0] o_count
);

    tanimoto_pkg::id_pair_t                        r_mem [tanimoto_pkg::FIFO_DEPTH];
    logic [$clog2(tanimoto_pkg::FIFO_DEPTH)-1:0]   r_wr_ptr;
    logic [$clog2(tanimoto_pkg::FIFO_DEPTH)-1:0]   r_rd_ptr;
    logic                                          w_do_wr;
    logic                                          w_do_rd;

    assign o_empty = (o_count == '0);
    assign o_full  = (o_count == tanimoto_pkg::FIFO_CNT_W'(tanimoto_pkg::FIFO_DEPTH));

    // Reads on empty and writes on full are dropped
    assign w_do_wr = i_wr & ~o_full;
    assign w_do_rd = i_rd & ~o_empty;

    // Fall-through head
    assign o_dout = r_mem[r_rd_ptr];

    always_ff @(posedge clk) begin
        if (w_do_wr) begin
            r_mem[r_wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            o_count  <= '0;
        end else begin
            if (w_do_wr) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (w_do_rd) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
            o_count <= o_count + tanimoto_pkg::FIFO_CNT_W'(w_do_wr)
                               - tanimoto_pkg::FIFO_CNT_W'(w_do_rd);
        end
    end

endmodule

`default_nettype wire

// ==== ref_stage.sv ====
`default_nettype none

module ref_stage (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            i_ref_shift,
    input  tanimoto_pkg::vec_beat_t         i_ref,
    output tanimoto_pkg::vec_beat_t         o_ref,
    input  tanimoto_pkg::vec_beat_t         i_cmp,
    output tanimoto_pkg::vec_beat_t         o_cmp,
    output logic [tanimoto_pkg::CNT_W-1:0]  o_and_cnt,
    input  logic [tanimoto_pkg::SUM_W-1:0]  i_max_sum,
    output logic                            o_hit_wr,
    output tanimoto_pkg::id_pair_t          o_hit_pair
);

    tanimoto_pkg::vec_beat_t        r_ref;
    tanimoto_pkg::vec_beat_t        r_cmp;
    logic [tanimoto_pkg::SUM_W-1:0] w_sum;
    logic                           w_hit;

    // Reference moves only while references are being loaded
    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_ref.valid <= 1'b0;
        end else if (i_ref_shift) begin
            r_ref <= i_ref;
        end
    end

    // Compare beat advances every cycle with its own valid bit
    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_cmp.valid <= 1'b0;
        end else begin
            r_cmp <= i_cmp;
        end
    end

    assign o_ref = r_ref;
    assign o_cmp = r_cmp;

    // C = popcount(ref AND cmp), sent out for the table lookup
    assign o_and_cnt = r_cmp.valid ?
                       tanimoto_pkg::ones_count(r_ref.vector & r_cmp.vector) : '0;

    assign w_sum = tanimoto_pkg::SUM_W'(r_ref.count) + tanimoto_pkg::SUM_W'(r_cmp.count);

    // Hit when A+B stays within the table entry for C
    assign w_hit = r_cmp.valid & r_ref.valid & (w_sum <= i_max_sum);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_hit_wr <= 1'b0;
        end else begin
            o_hit_wr <= w_hit;
        end
    end

    always_ff @(posedge clk) begin
        o_hit_pair.id_a <= r_ref.id;
        o_hit_pair.id_b <= r_cmp.id;
    end

endmodule

`default_nettype wire

// ==== threshold_table.sv ====
`default_nettype none

module threshold_table (
    input  logic                            clk,
    input  logic                            rstn,
    input  tanimoto_pkg::wb_req_t           i_wb,
    output logic [tanimoto_pkg::SUM_W-1:0]  o_wb_dat,
    output logic                            o_wb_ack,
    input  logic [tanimoto_pkg::CNT_W-1:0]  i_lookup_cnt [tanimoto_pkg::N_REF],
    output logic [tanimoto_pkg::SUM_W-1:0]  o_lookup_max [tanimoto_pkg::N_REF]
);

    logic [tanimoto_pkg::SUM_W-1:0] r_tbl [tanimoto_pkg::TBL_ENTRIES];
    logic                           w_req;
    logic                           w_adr_ok;

    // A held strobe is served once, then ack drops for a cycle
    assign w_req    = i_wb.cyc & i_wb.stb & ~o_wb_ack;
    assign w_adr_ok = (i_wb.adr < tanimoto_pkg::TBL_ENTRIES);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_wb_ack <= 1'b0;
            o_wb_dat <= '0;
            for (int i = 0; i < tanimoto_pkg::TBL_ENTRIES; i++) begin
                r_tbl[i] <= '0;
            end
        end else begin
            o_wb_ack <= w_req;
            if (w_req) begin
                if (i_wb.we && w_adr_ok) begin
                    r_tbl[i_wb.adr] <= i_wb.dat;
                end
                // Out of range addresses read back as zero
                o_wb_dat <= w_adr_ok ? r_tbl[i_wb.adr] : '0;
            end
        end
    end

    // One lookup port per stage, same cycle
    always_comb begin
        for (int k = 0; k < tanimoto_pkg::N_REF; k++) begin
            if (i_lookup_cnt[k] < tanimoto_pkg::TBL_ENTRIES) begin
                o_lookup_max[k] = r_tbl[i_lookup_cnt[k]];
            end else begin
                o_lookup_max[k] = '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tanimoto_pkg.sv ====
`default_nettype none

package tanimoto_pkg;

    // Datapath sizes
    localparam int VEC_W           = 32;
    localparam int CNT_W           = 6;
    localparam int SUM_W           = 7;
    localparam int ID_W            = 8;
    localparam int N_REF           = 4;

    // Hit FIFOs and input throttling
    localparam int FIFO_DEPTH      = 16;
    localparam int FIFO_CNT_W      = 5;
    localparam int IN_FLIGHT_SLACK = 8;

    // Threshold table, indexed by the AND count
    localparam int TBL_ENTRIES     = 33;
    localparam int WB_ADR_W        = 6;

    typedef struct packed {
        logic [VEC_W-1:0] vector;
        logic [CNT_W-1:0] count;
        logic [ID_W-1:0]  id;
        logic             valid;
        logic             last;
    } vec_beat_t;

    typedef struct packed {
        logic [ID_W-1:0] id_a;
        logic [ID_W-1:0] id_b;
    } id_pair_t;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [SUM_W-1:0]    dat;
    } wb_req_t;

    typedef enum logic [1:0] {
        LOAD_REF = 2'd0,
        COMPARE  = 2'd1,
        OVER     = 2'd2
    } run_state_t;

    function automatic logic [CNT_W-1:0] ones_count(input logic [VEC_W-1:0] vec);
        logic [CNT_W-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < VEC_W; i++) begin
            cnt = cnt + CNT_W'(vec[i]);
        end
        return cnt;
    endfunction

endpackage

`default_nettype wire
